/* decodePkg.sv */
`default_nettype none

package decodePkg;

	localparam int INSTR_WIDTH = 32;	// fixed by the ISA

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_REG    = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD_SUB = 3'd0;	// op and op-imm groups
	localparam logic [2:0] F3_SLL     = 3'd1;
	localparam logic [2:0] F3_SLT     = 3'd2;
	localparam logic [2:0] F3_SLTU    = 3'd3;
	localparam logic [2:0] F3_XOR     = 3'd4;
	localparam logic [2:0] F3_SRL_SRA = 3'd5;
	localparam logic [2:0] F3_OR      = 3'd6;
	localparam logic [2:0] F3_AND     = 3'd7;
	localparam logic [2:0] F3_BEQ  = 3'd0;	// branches
	localparam logic [2:0] F3_BNE  = 3'd1;
	localparam logic [2:0] F3_BLT  = 3'd4;
	localparam logic [2:0] F3_BGE  = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;
	localparam logic [2:0] F3_LB  = 3'd0;	// loads
	localparam logic [2:0] F3_LH  = 3'd1;
	localparam logic [2:0] F3_LW  = 3'd2;
	localparam logic [2:0] F3_LBU = 3'd4;
	localparam logic [2:0] F3_LHU = 3'd5;
	localparam logic [2:0] F3_SB = 3'd0;	// stores
	localparam logic [2:0] F3_SH = 3'd1;
	localparam logic [2:0] F3_SW = 3'd2;
	localparam logic [2:0] F3_PRIV  = 3'd0;	// ecall, ebreak, mret
	localparam logic [2:0] F3_CSRRW = 3'd1;
	localparam logic [2:0] F3_CSRRS = 3'd2;

	localparam logic [6:0] FUNCT7_BASE = 7'h00;
	localparam logic [6:0] FUNCT7_ALT  = 7'h20;	// sub, sra

	localparam logic [11:0] IMM_ECALL  = 12'h000;
	localparam logic [11:0] IMM_EBREAK = 12'h001;
	localparam logic [11:0] IMM_MRET   = 12'h302;

	typedef enum logic [3:0] {
		CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH, CLS_LOAD,
		CLS_STORE, CLS_IMM, CLS_REG, CLS_SYSTEM, CLS_INVALID
	} opClassT;
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_AND, ALU_OR
	} aluOpT;
	typedef enum logic [1:0] {SRCA_REG, SRCA_PC, SRCA_ZERO} aluSrcAT;
	typedef enum logic [1:0] {SRCB_REG, SRCB_IMM, SRCB_FOUR, SRCB_CSR} aluSrcBT;
	typedef enum logic [2:0] {
		IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
	} immSelT;
	typedef enum logic [2:0] {CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU} cmpCondT;
	typedef enum logic {RES_ALU, RES_MEM} resultSrcT;
	typedef enum logic [2:0] {ACC_BYTE, ACC_HALF, ACC_WORD, ACC_BYTE_U, ACC_HALF_U} accessT;
	typedef enum logic [1:0] {PC_JB, PC_JALR, PC_TRAP, PC_EPC} pcTargetT;
	typedef enum logic [1:0] {CSR_RS, CSR_OR, CSR_TRAP} csrSrcT;

endpackage

`default_nettype wire

/* opClassifier.sv */
`timescale 1ns/10ps
`default_nettype none

module opClassifier (
	input wire [6:0] opcode,
	output decodePkg::opClassT opClass
);

	always_comb begin
		case (opcode)
			decodePkg::OPC_LUI:    opClass = decodePkg::CLS_LUI;
			decodePkg::OPC_AUIPC:  opClass = decodePkg::CLS_AUIPC;
			decodePkg::OPC_JAL:    opClass = decodePkg::CLS_JAL;
			decodePkg::OPC_JALR:   opClass = decodePkg::CLS_JALR;
			decodePkg::OPC_BRANCH: opClass = decodePkg::CLS_BRANCH;
			decodePkg::OPC_LOAD:   opClass = decodePkg::CLS_LOAD;
			decodePkg::OPC_STORE:  opClass = decodePkg::CLS_STORE;
			decodePkg::OPC_IMM:    opClass = decodePkg::CLS_IMM;	// op-imm group
			decodePkg::OPC_REG:    opClass = decodePkg::CLS_REG;	// op group
			decodePkg::OPC_SYSTEM: opClass = decodePkg::CLS_SYSTEM;
			default:               opClass = decodePkg::CLS_INVALID;	// fences, custom, rv64
		endcase
	end

endmodule

`default_nettype wire

/* aluDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module aluDecode (
	input wire decodePkg::opClassT opClass,
	input wire [2:0] funct3,
	input wire [6:0] funct7,
	output decodePkg::aluOpT aluOp,
	output decodePkg::aluSrcAT aluSrcA,
	output decodePkg::aluSrcBT aluSrcB,
	output decodePkg::immSelT immSel,
	output logic isSlt,
	output decodePkg::cmpCondT cmpCond,
	output logic aluIllegal
);

	wire isImm = (opClass == decodePkg::CLS_IMM);	// op-imm, else op
	wire isAlt = (funct7 == decodePkg::FUNCT7_ALT);	// sub / sra
	wire funct7Bad = (funct7 != decodePkg::FUNCT7_BASE) && !isAlt;

	always_comb begin
		aluOp = decodePkg::ALU_ADD;
		aluSrcA = decodePkg::SRCA_REG;
		aluSrcB = decodePkg::SRCB_REG;
		immSel = decodePkg::IMM_NONE;
		isSlt = 1'b0;
		cmpCond = decodePkg::CMP_EQ;
		aluIllegal = 1'b0;
		case (opClass)
			decodePkg::CLS_LUI: begin
				aluSrcA = decodePkg::SRCA_ZERO;	// rd = 0 + imm
				aluSrcB = decodePkg::SRCB_IMM;
				immSel = decodePkg::IMM_U;
			end
			decodePkg::CLS_AUIPC: begin
				aluSrcA = decodePkg::SRCA_PC;	// rd = pc + imm
				aluSrcB = decodePkg::SRCB_IMM;
				immSel = decodePkg::IMM_U;
			end
			decodePkg::CLS_JAL, decodePkg::CLS_JALR: begin
				aluSrcA = decodePkg::SRCA_PC;	// link address pc + 4
				aluSrcB = decodePkg::SRCB_FOUR;
				immSel = (opClass == decodePkg::CLS_JAL) ? decodePkg::IMM_J : decodePkg::IMM_I;
			end
			decodePkg::CLS_BRANCH: begin
				immSel = decodePkg::IMM_B;	// rs1 vs rs2
				case (funct3)
					decodePkg::F3_BEQ:  cmpCond = decodePkg::CMP_EQ;
					decodePkg::F3_BNE:  cmpCond = decodePkg::CMP_NE;
					decodePkg::F3_BLT:  cmpCond = decodePkg::CMP_LT;
					decodePkg::F3_BGE:  cmpCond = decodePkg::CMP_GE;
					decodePkg::F3_BLTU: cmpCond = decodePkg::CMP_LTU;
					decodePkg::F3_BGEU: cmpCond = decodePkg::CMP_GEU;
					default:            aluIllegal = 1'b1;	// funct3 2 and 3
				endcase
			end
			decodePkg::CLS_LOAD, decodePkg::CLS_STORE: begin
				aluSrcB = decodePkg::SRCB_IMM;	// address rs1 + imm
				immSel = (opClass == decodePkg::CLS_LOAD) ? decodePkg::IMM_I : decodePkg::IMM_S;
			end
			decodePkg::CLS_IMM, decodePkg::CLS_REG: begin
				aluSrcB = isImm ? decodePkg::SRCB_IMM : decodePkg::SRCB_REG;
				immSel = isImm ? decodePkg::IMM_I : decodePkg::IMM_NONE;
				case (funct3)
					decodePkg::F3_ADD_SUB: begin
						aluOp = (!isImm && isAlt) ? decodePkg::ALU_SUB : decodePkg::ALU_ADD;
						aluIllegal = !isImm && funct7Bad;	// addi has imm in funct7 bits
					end
					decodePkg::F3_SLL: begin
						aluOp = decodePkg::ALU_SLL;
						immSel = isImm ? decodePkg::IMM_SHAMT : decodePkg::IMM_NONE;
						aluIllegal = funct7Bad;
					end
					decodePkg::F3_SLT, decodePkg::F3_SLTU: begin
						aluOp = decodePkg::ALU_SUB;	// compare through the subtractor
						isSlt = 1'b1;
						cmpCond = (funct3 == decodePkg::F3_SLT) ? decodePkg::CMP_LT :
							decodePkg::CMP_LTU;
					end
					decodePkg::F3_XOR: aluOp = decodePkg::ALU_XOR;
					decodePkg::F3_SRL_SRA: begin
						aluOp = isAlt ? decodePkg::ALU_SRA : decodePkg::ALU_SRL;
						immSel = isImm ? decodePkg::IMM_SHAMT : decodePkg::IMM_NONE;
						aluIllegal = funct7Bad;
					end
					decodePkg::F3_OR:  aluOp = decodePkg::ALU_OR;
					default:           aluOp = decodePkg::ALU_AND;	// only F3_AND left
				endcase
			end
			decodePkg::CLS_SYSTEM: begin
				aluSrcA = decodePkg::SRCA_ZERO;	// rd gets old csr value
				aluSrcB = decodePkg::SRCB_CSR;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* memDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module memDecode (
	input wire decodePkg::opClassT opClass,
	input wire [2:0] funct3,
	output logic memEnable,
	output logic memWrite,
	output decodePkg::resultSrcT resultSrc,
	output decodePkg::accessT access,
	output logic memIllegal
);

	always_comb begin
		memEnable = 1'b0;
		memWrite = 1'b0;
		resultSrc = decodePkg::RES_ALU;
		access = decodePkg::ACC_WORD;	// word unless told otherwise
		memIllegal = 1'b0;
		case (opClass)
			decodePkg::CLS_LOAD: begin
				memEnable = 1'b1;
				resultSrc = decodePkg::RES_MEM;	// rd from load data
				case (funct3)
					decodePkg::F3_LB:  access = decodePkg::ACC_BYTE;	// sign extended
					decodePkg::F3_LH:  access = decodePkg::ACC_HALF;
					decodePkg::F3_LW:  access = decodePkg::ACC_WORD;
					decodePkg::F3_LBU: access = decodePkg::ACC_BYTE_U;	// zero extended
					decodePkg::F3_LHU: access = decodePkg::ACC_HALF_U;
					default:           memIllegal = 1'b1;
				endcase
			end
			decodePkg::CLS_STORE: begin
				memEnable = 1'b1;
				memWrite = 1'b1;
				case (funct3)
					decodePkg::F3_SB: access = decodePkg::ACC_BYTE;
					decodePkg::F3_SH: access = decodePkg::ACC_HALF;
					decodePkg::F3_SW: access = decodePkg::ACC_WORD;
					default:          memIllegal = 1'b1;
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* flowDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module flowDecode (
	input wire decodePkg::opClassT opClass,
	input wire [2:0] funct3,
	input wire [11:0] imm12,
	output logic jump,
	output logic branch,
	output decodePkg::pcTargetT pcTarget,
	output logic csrWrite,
	output decodePkg::csrSrcT csrSrc,
	output logic halt,
	output logic flowIllegal
);

	always_comb begin
		jump = 1'b0;
		branch = 1'b0;
		pcTarget = decodePkg::PC_JB;
		csrWrite = 1'b0;
		csrSrc = decodePkg::CSR_RS;
		halt = 1'b0;
		flowIllegal = 1'b0;
		case (opClass)
			decodePkg::CLS_JAL: jump = 1'b1;	// pc + J imm
			decodePkg::CLS_JALR: begin
				jump = 1'b1;
				pcTarget = decodePkg::PC_JALR;	// rs1 + I imm
			end
			decodePkg::CLS_BRANCH: branch = 1'b1;	// taken decided in execute
			decodePkg::CLS_SYSTEM: begin
				case (funct3)
					decodePkg::F3_PRIV: begin
						case (imm12)
							decodePkg::IMM_ECALL: begin
								jump = 1'b1;	// into the trap vector
								pcTarget = decodePkg::PC_TRAP;
								csrWrite = 1'b1;	// save epc and cause
								csrSrc = decodePkg::CSR_TRAP;
							end
							decodePkg::IMM_MRET: begin
								jump = 1'b1;
								pcTarget = decodePkg::PC_EPC;	// back to mepc
							end
							decodePkg::IMM_EBREAK: halt = 1'b1;	// stops the core
							default: flowIllegal = 1'b1;
						endcase
					end
					decodePkg::F3_CSRRW: csrWrite = 1'b1;	// csr = rs1
					decodePkg::F3_CSRRS: begin
						csrWrite = 1'b1;
						csrSrc = decodePkg::CSR_OR;	// csr = csr | rs1
					end
					default: flowIllegal = 1'b1;	// csrrc and immediate forms not kept
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* idExRegister.sv */
`timescale 1ns/10ps
`default_nettype none

module idExRegister (
	input wire clk,
	input wire arstN,
	input wire instrValid,
	input wire decodePkg::opClassT opClass,
	input wire decodePkg::aluOpT decAluOp,
	input wire decodePkg::aluSrcAT decAluSrcA,
	input wire decodePkg::aluSrcBT decAluSrcB,
	input wire decodePkg::immSelT decImmSel,
	input wire decIsSlt,
	input wire decodePkg::cmpCondT decCmpCond,
	input wire aluIllegal,
	input wire decMemEnable,
	input wire decMemWrite,
	input wire decodePkg::resultSrcT decResultSrc,
	input wire decodePkg::accessT decAccess,
	input wire memIllegal,
	input wire decJump,
	input wire decBranch,
	input wire decodePkg::pcTargetT decPcTarget,
	input wire decCsrWrite,
	input wire decodePkg::csrSrcT decCsrSrc,
	input wire decHalt,
	input wire flowIllegal,
	output logic ctrlValid,
	output logic illegal,
	output logic regWrite,
	output logic memEnable,
	output logic memWrite,
	output decodePkg::resultSrcT resultSrc,
	output decodePkg::aluOpT aluOp,
	output decodePkg::aluSrcAT aluSrcA,
	output decodePkg::aluSrcBT aluSrcB,
	output decodePkg::immSelT immSel,
	output logic isSlt,
	output decodePkg::cmpCondT cmpCond,
	output logic jump,
	output logic branch,
	output decodePkg::pcTargetT pcTarget,
	output decodePkg::accessT access,
	output logic csrWrite,
	output decodePkg::csrSrcT csrSrc,
	output logic halt
);

	wire anyIllegal = aluIllegal || memIllegal || flowIllegal ||
		(opClass == decodePkg::CLS_INVALID);
	wire accept = instrValid && !anyIllegal;	// legal instruction this cycle
	logic regWriteNext;

	always_comb begin
		case (opClass)
			decodePkg::CLS_BRANCH, decodePkg::CLS_STORE, decodePkg::CLS_INVALID:
				regWriteNext = 1'b0;
			decodePkg::CLS_SYSTEM:	// only csrrw / csrrs write rd
				regWriteNext = decCsrWrite && (decCsrSrc != decodePkg::CSR_TRAP);
			default: regWriteNext = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlValid <= 1'b0;
			illegal <= 1'b0;
			regWrite <= 1'b0;
			memEnable <= 1'b0;
			memWrite <= 1'b0;
			jump <= 1'b0;
			branch <= 1'b0;
			csrWrite <= 1'b0;
			halt <= 1'b0;
			isSlt <= 1'b0;
			resultSrc <= decodePkg::RES_ALU;
			aluOp <= decodePkg::ALU_ADD;
			aluSrcA <= decodePkg::SRCA_REG;
			aluSrcB <= decodePkg::SRCB_REG;
			immSel <= decodePkg::IMM_NONE;
			cmpCond <= decodePkg::CMP_EQ;
			pcTarget <= decodePkg::PC_JB;
			access <= decodePkg::ACC_WORD;
			csrSrc <= decodePkg::CSR_RS;
		end else begin
			ctrlValid <= instrValid;	// high for illegal ones too
			illegal <= instrValid && anyIllegal;
			regWrite <= accept && regWriteNext;
			memEnable <= accept && decMemEnable;
			memWrite <= accept && decMemWrite;
			jump <= accept && decJump;
			branch <= accept && decBranch;
			csrWrite <= accept && decCsrWrite;
			halt <= accept && decHalt;	// one cycle pulse
			isSlt <= accept && decIsSlt;
			// fields fall back to defaults on idle or illegal
			resultSrc <= accept ? decResultSrc : decodePkg::RES_ALU;
			aluOp <= accept ? decAluOp : decodePkg::ALU_ADD;
			aluSrcA <= accept ? decAluSrcA : decodePkg::SRCA_REG;
			aluSrcB <= accept ? decAluSrcB : decodePkg::SRCB_REG;
			immSel <= accept ? decImmSel : decodePkg::IMM_NONE;
			cmpCond <= accept ? decCmpCond : decodePkg::CMP_EQ;
			pcTarget <= accept ? decPcTarget : decodePkg::PC_JB;
			access <= accept ? decAccess : decodePkg::ACC_WORD;
			csrSrc <= accept ? decCsrSrc : decodePkg::CSR_RS;
		end
	end

endmodule

`default_nettype wire

/* decodeCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeCtrl (
	input wire clk,
	input wire arstN,
	input wire [decodePkg::INSTR_WIDTH-1:0] instr,
	input wire instrValid,
	output wire ctrlValid,
	output wire illegal,
	output wire regWrite,
	output wire memEnable,
	output wire memWrite,
	output wire decodePkg::resultSrcT resultSrc,
	output wire decodePkg::aluOpT aluOp,
	output wire decodePkg::aluSrcAT aluSrcA,
	output wire decodePkg::aluSrcBT aluSrcB,
	output wire decodePkg::immSelT immSel,
	output wire isSlt,
	output wire decodePkg::cmpCondT cmpCond,
	output wire jump,
	output wire branch,
	output wire decodePkg::pcTargetT pcTarget,
	output wire decodePkg::accessT access,
	output wire csrWrite,
	output wire decodePkg::csrSrcT csrSrc,
	output wire halt
);

	wire [6:0] opcode = instr[6:0];
	wire [2:0] funct3 = instr[14:12];
	wire [6:0] funct7 = instr[31:25];
	wire [11:0] imm12 = instr[31:20];	// system function code

	wire decodePkg::opClassT opClass;
	wire decodePkg::aluOpT decAluOp;
	wire decodePkg::aluSrcAT decAluSrcA;
	wire decodePkg::aluSrcBT decAluSrcB;
	wire decodePkg::immSelT decImmSel;
	wire decodePkg::cmpCondT decCmpCond;
	wire decodePkg::resultSrcT decResultSrc;
	wire decodePkg::accessT decAccess;
	wire decodePkg::pcTargetT decPcTarget;
	wire decodePkg::csrSrcT decCsrSrc;
	wire decIsSlt;
	wire aluIllegal;
	wire decMemEnable;
	wire decMemWrite;
	wire memIllegal;
	wire decJump;
	wire decBranch;
	wire decCsrWrite;
	wire decHalt;
	wire flowIllegal;

	opClassifier opClassifier_i (
		.opcode(opcode),
		.opClass(opClass)
	);

	aluDecode aluDecode_i (
		.opClass(opClass),
		.funct3(funct3),
		.funct7(funct7),
		.aluOp(decAluOp),
		.aluSrcA(decAluSrcA),
		.aluSrcB(decAluSrcB),
		.immSel(decImmSel),
		.isSlt(decIsSlt),
		.cmpCond(decCmpCond),
		.aluIllegal(aluIllegal)
	);

	memDecode memDecode_i (
		.opClass(opClass),
		.funct3(funct3),
		.memEnable(decMemEnable),
		.memWrite(decMemWrite),
		.resultSrc(decResultSrc),
		.access(decAccess),
		.memIllegal(memIllegal)
	);

	flowDecode flowDecode_i (
		.opClass(opClass),
		.funct3(funct3),
		.imm12(imm12),
		.jump(decJump),
		.branch(decBranch),
		.pcTarget(decPcTarget),
		.csrWrite(decCsrWrite),
		.csrSrc(decCsrSrc),
		.halt(decHalt),
		.flowIllegal(flowIllegal)
	);

	idExRegister idExRegister_i (	// decode/execute boundary
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.opClass(opClass),
		.decAluOp(decAluOp),
		.decAluSrcA(decAluSrcA),
		.decAluSrcB(decAluSrcB),
		.decImmSel(decImmSel),
		.decIsSlt(decIsSlt),
		.decCmpCond(decCmpCond),
		.aluIllegal(aluIllegal),
		.decMemEnable(decMemEnable),
		.decMemWrite(decMemWrite),
		.decResultSrc(decResultSrc),
		.decAccess(decAccess),
		.memIllegal(memIllegal),
		.decJump(decJump),
		.decBranch(decBranch),
		.decPcTarget(decPcTarget),
		.decCsrWrite(decCsrWrite),
		.decCsrSrc(decCsrSrc),
		.decHalt(decHalt),
		.flowIllegal(flowIllegal),
		.ctrlValid(ctrlValid),
		.illegal(illegal),
		.regWrite(regWrite),
		.memEnable(memEnable),
		.memWrite(memWrite),
		.resultSrc(resultSrc),
		.aluOp(aluOp),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.immSel(immSel),
		.isSlt(isSlt),
		.cmpCond(cmpCond),
		.jump(jump),
		.branch(branch),
		.pcTarget(pcTarget),
		.access(access),
		.csrWrite(csrWrite),
		.csrSrc(csrSrc),
		.halt(halt)
	);

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;	// free running
	end

	initial begin
		arstN = 1'b0;	// in reset from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		#2 arstN = 1'b1;	// release clear of the edge
	end

endmodule

`default_nettype wire

/* decodeCtrlAssertions.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeCtrlAssertions (
	input wire clk,
	input wire arstN,
	input wire ctrlValid,
	input wire illegal,
	input wire regWrite,
	input wire memEnable,
	input wire memWrite,
	input wire jump,
	input wire branch,
	input wire csrWrite,
	input wire halt,
	input wire isSlt
);

	wire anyEnable = regWrite || memEnable || memWrite || jump || branch || csrWrite || halt;
	wire anyFlag = anyEnable || illegal || isSlt;

	storeNeedsEnable: assert property (@(posedge clk) disable iff (!arstN)
		memWrite |-> memEnable)
		else $error("memWrite high without memEnable");

	illegalBlocksEnables: assert property (@(posedge clk) disable iff (!arstN)
		illegal |-> !anyEnable)
		else $error("enable raised on an illegal instruction");

	jumpOrBranch: assert property (@(posedge clk) disable iff (!arstN)
		!(jump && branch))
		else $error("jump and branch high together");

	flagNeedsValid: assert property (@(posedge clk) disable iff (!arstN)
		anyFlag |-> ctrlValid)
		else $error("control flag high while ctrlValid is low");

endmodule

// checks sit on the pipeline register outputs
bind idExRegister decodeCtrlAssertions assertions_i (
	.clk(clk),
	.arstN(arstN),
	.ctrlValid(ctrlValid),
	.illegal(illegal),
	.regWrite(regWrite),
	.memEnable(memEnable),
	.memWrite(memWrite),
	.jump(jump),
	.branch(branch),
	.csrWrite(csrWrite),
	.halt(halt),
	.isSlt(isSlt)
);

`default_nettype wire

/* decodeCtrlTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeCtrlTb;

	localparam int FIELDS = 20;	// instr word plus 19 outputs
	localparam int MAX_VECTORS = 64;
	localparam int PERIOD = 20;

	wire clk;
	wire arstN;
	logic [31:0] instr;
	logic instrValid;
	wire ctrlValid;
	wire illegal;
	wire regWrite;
	wire memEnable;
	wire memWrite;
	wire resultSrc;
	wire [2:0] aluOp;
	wire [1:0] aluSrcA;
	wire [1:0] aluSrcB;
	wire [2:0] immSel;
	wire isSlt;
	wire [2:0] cmpCond;
	wire jump;
	wire branch;
	wire [1:0] pcTarget;
	wire [2:0] access;
	wire csrWrite;
	wire [1:0] csrSrc;
	wire halt;

	logic [31:0] vecMem [0:MAX_VECTORS*FIELDS-1];
	int expectQ[$];	// vector index per cycle, -1 for idle
	int vecCount;
	logic [31:0] lcgState;
	bit loaded;

	tbClock #(.PERIOD(PERIOD), .RESET_CYCLES(3)) clock_i (.clk(clk), .arstN(arstN));

	decodeCtrl dut_i (.*);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;	// low bits cycle too fast
	endfunction

	function automatic int readOutput(int field);
		case (field)
			1: return int'(ctrlValid);
			2: return int'(illegal);
			3: return int'(regWrite);
			4: return int'(memEnable);
			5: return int'(memWrite);
			6: return int'(resultSrc);
			7: return int'(aluOp);
			8: return int'(aluSrcA);
			9: return int'(aluSrcB);
			10: return int'(immSel);
			11: return int'(isSlt);
			12: return int'(cmpCond);
			13: return int'(jump);
			14: return int'(branch);
			15: return int'(pcTarget);
			16: return int'(access);
			17: return int'(csrWrite);
			18: return int'(csrSrc);
			default: return int'(halt);
		endcase
	endfunction

	function automatic string fieldName(int field);
		case (field)
			1: return "ctrlValid";
			2: return "illegal";
			3: return "regWrite";
			4: return "memEnable";
			5: return "memWrite";
			6: return "resultSrc";
			7: return "aluOp";
			8: return "aluSrcA";
			9: return "aluSrcB";
			10: return "immSel";
			11: return "isSlt";
			12: return "cmpCond";
			13: return "jump";
			14: return "branch";
			15: return "pcTarget";
			16: return "access";
			17: return "csrWrite";
			18: return "csrSrc";
			default: return "halt";
		endcase
	endfunction

	// idle and reset: all low, access rests at WORD
	function automatic int expectedValue(int idx, int field);
		if (idx < 0)
			return (field == 16) ? 2 : 0;
		return int'(vecMem[idx * FIELDS + field]);
	endfunction

	task automatic checkFront();
		int idx;
		int f;
		int expected;
		int actual;
		string testName;
		idx = expectQ.pop_front();
		if (idx < 0)
			testName = "idle";
		else
			testName = $sformatf("vector %0d instr %h", idx, vecMem[idx * FIELDS]);
		for (f = 1; f < FIELDS; f++) begin
			expected = expectedValue(idx, f);
			actual = readOutput(f);
			assert (actual == expected) else begin
				$display("Fail %s %s: expected %0d, actual %0d",
					testName, fieldName(f), expected, actual);
				$display("Simulation failed");
				$fatal(1, "output mismatch");
			end
		end
	endtask

	// check what the last edge registered, then drive the next input
	task automatic stepCycle(input logic [31:0] word, input logic valid, input int idx);
		@(posedge clk);
		#2;	// outputs settled, inputs change here
		checkFront();
		instr = word;
		instrValid = valid;
		expectQ.push_back(idx);
	endtask

	initial begin
		int gaps;
		int v;
		instr = '0;
		instrValid = 1'b0;
		lcgState = 32'd30;	// seed
		vecCount = 0;
		$readmemh("decodeCtrlTestdata.txt", vecMem);
		while (vecCount < MAX_VECTORS && vecMem[vecCount * FIELDS + 1] == 32'd1)
			vecCount++;	// list ends at a ctrlValid of 0
		assert (vecCount > 0) else begin
			$display("no test vectors found in decodeCtrlTestdata.txt");
			$display("Simulation failed");
			$fatal(1, "empty test data");
		end
		loaded = 1'b1;
		expectQ.push_back(-1);
		@(posedge clk);
		#2;
		checkFront();	// values while reset is held
		wait (arstN);
		expectQ.push_back(-1);	// first cycle out of reset
		for (v = 0; v < vecCount; v++) begin
			gaps = int'(nextRandom() % 3);	// 0..2 idle cycles
			repeat (gaps) stepCycle(vecMem[v * FIELDS], 1'b0, -1);	// next word, not valid yet
			stepCycle(vecMem[v * FIELDS], 1'b1, v);
		end
		stepCycle('0, 1'b0, -1);	// last vector comes out
		@(posedge clk);
		#2;
		checkFront();
		$display("Simulation completed successfully");
		$finish;
	end

	// worst case is two idle cycles per vector
	initial begin
		wait (loaded);
		#((vecCount * 3 + 10) * PERIOD);
		$display("watchdog expired before all vectors were checked");
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* decodeCtrlTestdata.txt */
// instr cv il rw me mw rs aop sa sb imm slt cmp j br pc acc cw cs h
// fields are decodePkg enum numbers; a line with ctrlValid 0 ends the list
00510093 1 0 1 0 0 0 0 0 1 1 0 0 0 0 0 2 0 0 0 // addi
fff10093 1 0 1 0 0 0 0 0 1 1 0 0 0 0 0 2 0 0 0 // addi -1
00512093 1 0 1 0 0 0 1 0 1 1 1 2 0 0 0 2 0 0 0 // slti
00513093 1 0 1 0 0 0 1 0 1 1 1 4 0 0 0 2 0 0 0 // sltiu
00514093 1 0 1 0 0 0 5 0 1 1 0 0 0 0 0 2 0 0 0 // xori
00516093 1 0 1 0 0 0 7 0 1 1 0 0 0 0 0 2 0 0 0 // ori
00517093 1 0 1 0 0 0 6 0 1 1 0 0 0 0 0 2 0 0 0 // andi
00311093 1 0 1 0 0 0 2 0 1 6 0 0 0 0 0 2 0 0 0 // slli
00315093 1 0 1 0 0 0 3 0 1 6 0 0 0 0 0 2 0 0 0 // srli
40315093 1 0 1 0 0 0 4 0 1 6 0 0 0 0 0 2 0 0 0 // srai
003100b3 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // add
403100b3 1 0 1 0 0 0 1 0 0 0 0 0 0 0 0 2 0 0 0 // sub
003110b3 1 0 1 0 0 0 2 0 0 0 0 0 0 0 0 2 0 0 0 // sll
003120b3 1 0 1 0 0 0 1 0 0 0 1 2 0 0 0 2 0 0 0 // slt
003130b3 1 0 1 0 0 0 1 0 0 0 1 4 0 0 0 2 0 0 0 // sltu
003140b3 1 0 1 0 0 0 5 0 0 0 0 0 0 0 0 2 0 0 0 // xor
003150b3 1 0 1 0 0 0 3 0 0 0 0 0 0 0 0 2 0 0 0 // srl
403150b3 1 0 1 0 0 0 4 0 0 0 0 0 0 0 0 2 0 0 0 // sra
003160b3 1 0 1 0 0 0 7 0 0 0 0 0 0 0 0 2 0 0 0 // or
003170b3 1 0 1 0 0 0 6 0 0 0 0 0 0 0 0 2 0 0 0 // and
00810083 1 0 1 1 0 1 0 0 1 1 0 0 0 0 0 0 0 0 0 // lb
00811083 1 0 1 1 0 1 0 0 1 1 0 0 0 0 0 1 0 0 0 // lh
00812083 1 0 1 1 0 1 0 0 1 1 0 0 0 0 0 2 0 0 0 // lw
00814083 1 0 1 1 0 1 0 0 1 1 0 0 0 0 0 3 0 0 0 // lbu
00815083 1 0 1 1 0 1 0 0 1 1 0 0 0 0 0 4 0 0 0 // lhu
00310423 1 0 0 1 1 0 0 0 1 2 0 0 0 0 0 0 0 0 0 // sb
00311423 1 0 0 1 1 0 0 0 1 2 0 0 0 0 0 1 0 0 0 // sh
00312423 1 0 0 1 1 0 0 0 1 2 0 0 0 0 0 2 0 0 0 // sw
00310463 1 0 0 0 0 0 0 0 0 3 0 0 0 1 0 2 0 0 0 // beq
00311463 1 0 0 0 0 0 0 0 0 3 0 1 0 1 0 2 0 0 0 // bne
00314463 1 0 0 0 0 0 0 0 0 3 0 2 0 1 0 2 0 0 0 // blt
00315463 1 0 0 0 0 0 0 0 0 3 0 3 0 1 0 2 0 0 0 // bge
00316463 1 0 0 0 0 0 0 0 0 3 0 4 0 1 0 2 0 0 0 // bltu
00317463 1 0 0 0 0 0 0 0 0 3 0 5 0 1 0 2 0 0 0 // bgeu
010000ef 1 0 1 0 0 0 0 1 2 5 0 0 1 0 0 2 0 0 0 // jal
000100e7 1 0 1 0 0 0 0 1 2 1 0 0 1 0 1 2 0 0 0 // jalr
123450b7 1 0 1 0 0 0 0 2 1 4 0 0 0 0 0 2 0 0 0 // lui
12345097 1 0 1 0 0 0 0 1 1 4 0 0 0 0 0 2 0 0 0 // auipc
00000073 1 0 0 0 0 0 0 2 3 0 0 0 1 0 2 2 1 2 0 // ecall
30200073 1 0 0 0 0 0 0 2 3 0 0 0 1 0 3 2 0 0 0 // mret
00100073 1 0 0 0 0 0 0 2 3 0 0 0 0 0 0 2 0 0 1 // ebreak
340110f3 1 0 1 0 0 0 0 2 3 0 0 0 0 0 0 2 1 0 0 // csrrw
340120f3 1 0 1 0 0 0 0 2 3 0 0 0 0 0 0 2 1 1 0 // csrrs
0000000f 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // fence, unknown opcode
00813083 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // ld, bad load funct3
00313423 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // sd, bad store funct3
00312463 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // branch funct3 2
023100b3 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // mul, bad funct7
10500073 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // wfi, unknown system imm
340130f3 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 // csrrc
00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 // end of list

/* sources.f */
decodePkg.sv
opClassifier.sv
aluDecode.sv
memDecode.sv
flowDecode.sv
idExRegister.sv
decodeCtrl.sv
tbClock.sv
decodeCtrlAssertions.sv
decodeCtrlTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --assert
TOP = decodeCtrlTb
FILELIST = sources.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM) decodeCtrlTestdata.txt
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
